// File: core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// entries in each register file.
`define CORE_NREGS 32

// first instruction address after reset.
`define CORE_RESET_PC 32'h0000_0000

// instruction bus address width.
`define CORE_AXI_ADDR_W 32

// longest serial shift, in cycles after the start pulse.
`define CORE_MAX_SHIFT_LAT 32

`endif

// File: core_pkg.sv
package core_pkg;

	typedef enum logic [5:0] {
		ADD     = 6'h00,
		SUB     = 6'h01,
		AND     = 6'h02,
		OR      = 6'h03,
		XOR     = 6'h04,
		SLT     = 6'h05,
		SLL     = 6'h06,
		SRL     = 6'h07,
		SRA     = 6'h08,
		ADDI    = 6'h09,
		ORI     = 6'h0a,
		LUI     = 6'h0b,
		BEQ     = 6'h0c,
		BNE     = 6'h0d,
		J       = 6'h0e,
		MTF     = 6'h0f,
		MFF     = 6'h10,
		FMOV    = 6'h11,
		FNEG    = 6'h12,
		FABS    = 6'h13,
		ILLEGAL = 6'h3e,
		HALT    = 6'h3f
	} opcode_e;

	typedef enum logic [2:0] {
		INIT,
		FETCH,
		DECODE,
		EXEC,
		HALTED
	} ctrl_state_e;

	// fields of one instruction word, plus which file it writes.
	typedef struct packed {
		opcode_e     op;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [4:0]  shift5;
		logic [15:0] const16;
		logic [25:0] addr26;
		logic        dest_general;
		logic        dest_float;
	} decoded_s;

	typedef struct packed {
		logic [31:0] value;
		logic [31:0] next_pc;
		logic [4:0]  dest;
		logic        dest_general;
		logic        dest_float;
		logic        halt;
	} exec_result_s;

	// one record per retired instruction.
	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] instruction;
		logic [4:0]  dest;
		logic        wrote_general;
		logic        wrote_float;
		logic [31:0] value;
	} trace_s;

endpackage

// File: inst_fetcher.sv
`include "core_config.svh"

module inst_fetcher
	(
	input  logic                        clk_i,
	input  logic                        reset_i,
	input  logic                        fetch_req_i,
	input  logic [`CORE_AXI_ADDR_W-1:0] fetch_addr_i,
	output logic                        fetch_done_o,
	output logic [31:0]                 fetch_word_o,
	output logic                        fetch_fault_o,
	output logic                        m_arvalid_o,
	input  logic                        m_arready_i,
	output logic [`CORE_AXI_ADDR_W-1:0] m_araddr_o,
	input  logic                        m_rvalid_i,
	output logic                        m_rready_o,
	input  logic [31:0]                 m_rdata_i,
	input  logic [1:0]                  m_rresp_i
	);

	typedef enum logic [1:0] {S_IDLE, S_ADDR, S_DATA} fetch_state_e;

	fetch_state_e state_q;
	logic [`CORE_AXI_ADDR_W-1:0] addr_q;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state_q <= S_IDLE;
		end else begin
			case (state_q)
				S_IDLE: begin
					if (fetch_req_i)
						state_q <= S_ADDR;
				end
				S_ADDR: begin
					if (m_arready_i)
						state_q <= S_DATA;
				end
				S_DATA: begin
					if (m_rvalid_i)
						state_q <= S_IDLE;
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (state_q == S_IDLE && fetch_req_i)
			addr_q <= fetch_addr_i;
	end

	assign m_arvalid_o = (state_q == S_ADDR);
	assign m_araddr_o = addr_q;
	assign m_rready_o = (state_q == S_DATA);

	// the read beat itself completes the fetch.
	assign fetch_done_o = (state_q == S_DATA) && m_rvalid_i;
	assign fetch_word_o = m_rdata_i;
	// anything but OKAY is a fault.
	assign fetch_fault_o = (m_rresp_i != 2'b00);

	a_araddr_hold: assert property (@(posedge clk_i) disable iff (reset_i)
		m_arvalid_o && !m_arready_i |=> m_arvalid_o && $stable(m_araddr_o));

	a_req_when_idle: assert property (@(posedge clk_i) disable iff (reset_i)
		fetch_req_i |-> state_q == S_IDLE);

endmodule

// File: inst_decoder.sv
module inst_decoder
	(
	input  logic [31:0]          instruction_i,
	output core_pkg::decoded_s   decoded_o
	);
	import core_pkg::*;

	logic [5:0] code;

	assign code = instruction_i[31:26];

	always_comb begin
		decoded_o.rs = instruction_i[25:21];
		decoded_o.rt = instruction_i[20:16];
		decoded_o.rd = instruction_i[15:11];
		decoded_o.shift5 = instruction_i[10:6];
		decoded_o.const16 = instruction_i[15:0];
		decoded_o.addr26 = instruction_i[25:0];

		// unknown codes fall through to ILLEGAL.
		case (code)
			ADD, SUB, AND, OR, XOR, SLT,
			SLL, SRL, SRA,
			ADDI, ORI, LUI,
			BEQ, BNE, J,
			MTF, MFF, FMOV, FNEG, FABS,
			HALT: decoded_o.op = opcode_e'(code);
			default: decoded_o.op = ILLEGAL;
		endcase

		decoded_o.dest_general = 1'b0;
		decoded_o.dest_float = 1'b0;
		case (decoded_o.op)
			ADD, SUB, AND, OR, XOR, SLT,
			SLL, SRL, SRA,
			ADDI, ORI, LUI: begin
				decoded_o.dest_general = 1'b1;
			end
			MFF: begin
				decoded_o.dest_general = 1'b1;
			end
			MTF, FMOV, FNEG, FABS: begin
				decoded_o.dest_float = 1'b1;
			end
			// branches, jumps and stops write nothing.
			default: begin
				decoded_o.dest_general = 1'b0;
				decoded_o.dest_float = 1'b0;
			end
		endcase
	end

endmodule

// File: executor.sv
`include "core_config.svh"

module executor
	(
	input  logic                     clk_i,
	input  logic                     reset_i,
	input  logic                     start_i,
	input  core_pkg::decoded_s       decoded_i,
	input  logic [31:0]              gen_op_i [3],
	input  logic [31:0]              flt_op_i [3],
	input  logic [31:0]              pc_i,
	output logic                     done_o,
	output core_pkg::exec_result_s   result_o
	);
	import core_pkg::*;

	logic        busy_q;
	logic [4:0]  cnt_q;
	logic [31:0] acc_q;
	logic        is_shift;
	logic        serial;
	logic        taken;
	logic [31:0] pc_plus4;
	logic [31:0] sext16;
	logic [31:0] alu_value;

	function automatic logic [31:0] shift_one(opcode_e op, logic [31:0] v);
		case (op)
			SLL:     shift_one = {v[30:0], 1'b0};
			SRL:     shift_one = {1'b0, v[31:1]};
			default: shift_one = {v[31], v[31:1]};
		endcase
	endfunction

	assign is_shift = decoded_i.op inside {SLL, SRL, SRA};
	// a shift by zero finishes like any other op.
	assign serial = is_shift && (decoded_i.shift5 != 5'd0);
	assign pc_plus4 = pc_i + 32'd4;
	assign sext16 = {{16{decoded_i.const16[15]}}, decoded_i.const16};
	assign taken = (decoded_i.op == BEQ) ? (gen_op_i[0] == gen_op_i[1]) :
		(decoded_i.op == BNE) ? (gen_op_i[0] != gen_op_i[1]) : 1'b0;

	always_comb begin
		case (decoded_i.op)
			ADD:           alu_value = gen_op_i[0] + gen_op_i[1];
			SUB:           alu_value = gen_op_i[0] - gen_op_i[1];
			AND:           alu_value = gen_op_i[0] & gen_op_i[1];
			OR:            alu_value = gen_op_i[0] | gen_op_i[1];
			XOR:           alu_value = gen_op_i[0] ^ gen_op_i[1];
			SLT:           alu_value = {31'd0, $signed(gen_op_i[0]) < $signed(gen_op_i[1])};
			SLL, SRL, SRA: alu_value = gen_op_i[1];
			ADDI:          alu_value = gen_op_i[0] + sext16;
			ORI:           alu_value = gen_op_i[0] | {16'd0, decoded_i.const16};
			LUI:           alu_value = {decoded_i.const16, 16'd0};
			MTF:           alu_value = gen_op_i[0];
			MFF, FMOV:     alu_value = flt_op_i[0];
			FNEG:          alu_value = {~flt_op_i[0][31], flt_op_i[0][30:0]};
			FABS:          alu_value = {1'b0, flt_op_i[0][30:0]};
			default:       alu_value = 32'd0;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			busy_q <= 1'b0;
			cnt_q <= 5'd0;
		end else if (start_i && serial) begin
			busy_q <= 1'b1;
			cnt_q <= decoded_i.shift5 - 5'd1;
		end else if (busy_q) begin
			if (cnt_q == 5'd0)
				busy_q <= 1'b0;
			else
				cnt_q <= cnt_q - 5'd1;
		end
	end

	// first bit moves on the start cycle, one more per cycle after.
	always_ff @(posedge clk_i) begin
		if (start_i)
			acc_q <= shift_one(decoded_i.op, gen_op_i[1]);
		else if (busy_q)
			acc_q <= shift_one(decoded_i.op, acc_q);
	end

	assign done_o = (start_i && !serial) || (busy_q && cnt_q == 5'd0);

	always_comb begin
		result_o.value = busy_q ? acc_q : alu_value;
		result_o.dest = (decoded_i.op inside {ADDI, ORI, LUI}) ? decoded_i.rt : decoded_i.rd;
		result_o.dest_general = decoded_i.dest_general;
		result_o.dest_float = decoded_i.dest_float;
		result_o.halt = decoded_i.op inside {HALT, ILLEGAL};
		if (taken)
			result_o.next_pc = pc_plus4 + {sext16[29:0], 2'b00};
		else if (decoded_i.op == J)
			result_o.next_pc = {pc_plus4[31:28], decoded_i.addr26, 2'b00};
		else
			result_o.next_pc = pc_plus4;
	end

	a_done_bound: assert property (@(posedge clk_i) disable iff (reset_i)
		start_i |-> ##[0:`CORE_MAX_SHIFT_LAT] done_o);

endmodule

// File: register_files.sv
`include "core_config.svh"

module register_files
	(
	input  logic                     clk_i,
	input  logic                     reset_i,
	input  logic [4:0]               rd_num_i [3],
	output logic [31:0]              gen_rd_o [3],
	output logic [31:0]              flt_rd_o [3],
	input  logic                     wr_en_i,
	input  core_pkg::exec_result_s   wr_i
	);

	logic [31:0] gen_q [`CORE_NREGS];
	logic [31:0] flt_q [`CORE_NREGS];

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			for (int i = 0; i < `CORE_NREGS; i++) begin
				gen_q[i] <= 32'd0;
				flt_q[i] <= 32'd0;
			end
		end else if (wr_en_i) begin
			// general r0 is hardwired to zero.
			if (wr_i.dest_general && wr_i.dest != 5'd0)
				gen_q[wr_i.dest] <= wr_i.value;
			// float f0 is an ordinary register.
			if (wr_i.dest_float)
				flt_q[wr_i.dest] <= wr_i.value;
		end
	end

	always_comb begin
		for (int p = 0; p < 3; p++) begin
			gen_rd_o[p] = gen_q[rd_num_i[p]];
			flt_rd_o[p] = flt_q[rd_num_i[p]];
		end
	end

endmodule

// File: core_controller.sv
`include "core_config.svh"

module core_controller
	(
	input  logic                        clk_i,
	input  logic                        reset_i,
	output logic                        fetch_req_o,
	output logic [`CORE_AXI_ADDR_W-1:0] fetch_addr_o,
	input  logic                        fetch_done_i,
	input  logic [31:0]                 fetch_word_i,
	input  logic                        fetch_fault_i,
	output logic                        exec_start_o,
	output core_pkg::decoded_s          decoded_o,
	output logic [31:0]                 gen_op_o [3],
	output logic [31:0]                 flt_op_o [3],
	output logic [31:0]                 pc_o,
	input  logic                        exec_done_i,
	input  core_pkg::exec_result_s      exec_result_i,
	output logic                        trace_valid_o,
	output core_pkg::trace_s            trace_o,
	output logic                        halted_o,
	output logic                        fault_o
	);
	import core_pkg::*;

	ctrl_state_e state_q;
	ctrl_state_e state_d;
	logic [31:0] pc_q;
	logic [31:0] ir_q;
	logic [4:0]  rd_num [3];
	logic        fetch_req_q;
	logic        exec_start_q;
	logic        retire;

	inst_decoder u_decoder (
		.instruction_i (ir_q),
		.decoded_o     (decoded_o)
	);

	assign rd_num[0] = decoded_o.rs;
	assign rd_num[1] = decoded_o.rt;
	assign rd_num[2] = decoded_o.rd;

	assign retire = (state_q == EXEC) && exec_done_i;

	register_files u_regs (
		.clk_i    (clk_i),
		.reset_i  (reset_i),
		.rd_num_i (rd_num),
		.gen_rd_o (gen_op_o),
		.flt_rd_o (flt_op_o),
		.wr_en_i  (retire),
		.wr_i     (exec_result_i)
	);

	always_comb begin
		state_d = state_q;
		case (state_q)
			INIT: state_d = FETCH;
			FETCH: begin
				if (fetch_done_i)
					state_d = fetch_fault_i ? HALTED : DECODE;
			end
			DECODE: state_d = EXEC;
			EXEC: begin
				if (exec_done_i)
					state_d = exec_result_i.halt ? HALTED : FETCH;
			end
			default: state_d = HALTED;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state_q <= INIT;
			pc_q <= `CORE_RESET_PC;
			fetch_req_q <= 1'b0;
			exec_start_q <= 1'b0;
			trace_valid_o <= 1'b0;
			fault_o <= 1'b0;
		end else begin
			state_q <= state_d;
			// pulses mark entry into a state.
			fetch_req_q <= (state_d == FETCH) && (state_q != FETCH);
			exec_start_q <= (state_d == EXEC) && (state_q != EXEC);
			trace_valid_o <= retire;
			if (retire)
				pc_q <= exec_result_i.next_pc;
			if (state_q == FETCH && fetch_done_i && fetch_fault_i)
				fault_o <= 1'b1;
		end
	end

	always_ff @(posedge clk_i) begin
		if (state_q == FETCH && fetch_done_i)
			ir_q <= fetch_word_i;
		if (retire) begin
			trace_o.pc <= pc_q;
			trace_o.instruction <= ir_q;
			trace_o.dest <= exec_result_i.dest;
			trace_o.wrote_general <= exec_result_i.dest_general;
			trace_o.wrote_float <= exec_result_i.dest_float;
			trace_o.value <= exec_result_i.value;
		end
	end

	assign fetch_req_o = fetch_req_q;
	assign fetch_addr_o = pc_q;
	assign exec_start_o = exec_start_q;
	assign pc_o = pc_q;
	assign halted_o = (state_q == HALTED);

	a_done_in_exec: assert property (@(posedge clk_i) disable iff (reset_i)
		exec_done_i |-> state_q == EXEC);

endmodule

// File: core_top.sv
`include "core_config.svh"

module core_top
	(
	input  logic                        clk,
	input  logic                        reset,
	output logic                        m_arvalid_o,
	input  logic                        m_arready_i,
	output logic [`CORE_AXI_ADDR_W-1:0] m_araddr_o,
	input  logic                        m_rvalid_i,
	output logic                        m_rready_o,
	input  logic [31:0]                 m_rdata_i,
	input  logic [1:0]                  m_rresp_i,
	output logic                        trace_valid_o,
	output core_pkg::trace_s            trace_o,
	output logic                        halted_o,
	output logic                        fault_o
	);
	import core_pkg::*;

	logic                        fetch_req;
	logic [`CORE_AXI_ADDR_W-1:0] fetch_addr;
	logic                        fetch_done;
	logic [31:0]                 fetch_word;
	logic                        fetch_fault;
	logic                        exec_start;
	logic                        exec_done;
	decoded_s                    decoded;
	exec_result_s                exec_result;
	logic [31:0]                 gen_op [3];
	logic [31:0]                 flt_op [3];
	logic [31:0]                 pc;

	core_controller u_ctrl (
		.clk_i         (clk),
		.reset_i       (reset),
		.fetch_req_o   (fetch_req),
		.fetch_addr_o  (fetch_addr),
		.fetch_done_i  (fetch_done),
		.fetch_word_i  (fetch_word),
		.fetch_fault_i (fetch_fault),
		.exec_start_o  (exec_start),
		.decoded_o     (decoded),
		.gen_op_o      (gen_op),
		.flt_op_o      (flt_op),
		.pc_o          (pc),
		.exec_done_i   (exec_done),
		.exec_result_i (exec_result),
		.trace_valid_o (trace_valid_o),
		.trace_o       (trace_o),
		.halted_o      (halted_o),
		.fault_o       (fault_o)
	);

	inst_fetcher u_fetch (
		.clk_i         (clk),
		.reset_i       (reset),
		.fetch_req_i   (fetch_req),
		.fetch_addr_i  (fetch_addr),
		.fetch_done_o  (fetch_done),
		.fetch_word_o  (fetch_word),
		.fetch_fault_o (fetch_fault),
		.m_arvalid_o   (m_arvalid_o),
		.m_arready_i   (m_arready_i),
		.m_araddr_o    (m_araddr_o),
		.m_rvalid_i    (m_rvalid_i),
		.m_rready_o    (m_rready_o),
		.m_rdata_i     (m_rdata_i),
		.m_rresp_i     (m_rresp_i)
	);

	executor u_exec (
		.clk_i     (clk),
		.reset_i   (reset),
		.start_i   (exec_start),
		.decoded_i (decoded),
		.gen_op_i  (gen_op),
		.flt_op_i  (flt_op),
		.pc_i      (pc),
		.done_o    (exec_done),
		.result_o  (exec_result)
	);

endmodule

// File: tb_imem.sv
module tb_imem #(
	parameter int MAX_DELAY = 3
) (
	input  logic        clk_i,
	input  logic        reset_i,
	input  logic        arvalid_i,
	output logic        arready_o,
	input  logic [31:0] araddr_i,
	output logic        rvalid_o,
	input  logic        rready_i,
	output logic [31:0] rdata_o,
	output logic [1:0]  rresp_o
);
	timeunit 1ns;
	timeprecision 1ps;

	typedef enum logic [2:0] {
		M_IDLE,
		M_ADDR_WAIT,
		M_ADDR_ACC,
		M_DATA_WAIT,
		M_DATA_BEAT
	} mem_phase_e;

	// program image that the testbench writes before each reset.
	logic [31:0] mem [256];
	bit          err_en;
	logic [31:0] err_addr;

	// accepted read addresses since the last reset.
	logic [31:0] addr_log [64];
	int          n_fetch = 0;
	// cycles where rready disagreed with the bus phase.
	int          rready_errors = 0;

	integer      seed = 32'h549b;
	mem_phase_e  phase = M_IDLE;
	int          wait_cnt = 0;
	logic [31:0] addr_q = 32'h0;
	logic        arready_q = 1'b0;
	logic        rvalid_q = 1'b0;
	logic [31:0] rdata_q = 32'h0;
	logic [1:0]  rresp_q = 2'b00;

	assign arready_o = arready_q;
	assign rvalid_o = rvalid_q;
	assign rdata_o = rdata_q;
	assign rresp_o = rresp_q;

	function automatic int draw_delay();
		draw_delay = ($random(seed) & 32'h7fff_ffff) % (MAX_DELAY + 1);
	endfunction

	always @(negedge clk_i) begin
		if (reset_i) begin
			phase <= M_IDLE;
			wait_cnt <= 0;
			arready_q <= 1'b0;
			rvalid_q <= 1'b0;
			rresp_q <= 2'b00;
			n_fetch <= 0;
			rready_errors <= 0;
		end else begin
			// rready is high from address acceptance until the data beat.
			if (rready_i !== (phase == M_ADDR_ACC || phase == M_DATA_WAIT))
				rready_errors <= rready_errors + 1;
			case (phase)
				M_IDLE: begin
					if (arvalid_i) begin
						wait_cnt <= draw_delay();
						phase <= M_ADDR_WAIT;
					end
				end
				M_ADDR_WAIT: begin
					if (wait_cnt == 0) begin
						// araddr holds while arvalid waits.
						arready_q <= 1'b1;
						addr_q <= araddr_i;
						phase <= M_ADDR_ACC;
					end else begin
						wait_cnt <= wait_cnt - 1;
					end
				end
				M_ADDR_ACC: begin
					arready_q <= 1'b0;
					if (n_fetch < 64)
						addr_log[n_fetch] <= addr_q;
					n_fetch <= n_fetch + 1;
					wait_cnt <= draw_delay();
					phase <= M_DATA_WAIT;
				end
				M_DATA_WAIT: begin
					if (wait_cnt == 0) begin
						rvalid_q <= 1'b1;
						rdata_q <= mem[addr_q[9:2]];
						rresp_q <= (err_en && addr_q == err_addr) ? 2'b10 : 2'b00;
						phase <= M_DATA_BEAT;
					end else begin
						wait_cnt <= wait_cnt - 1;
					end
				end
				default: begin
					// the beat went through at the last rising edge.
					rvalid_q <= 1'b0;
					rresp_q <= 2'b00;
					phase <= M_IDLE;
				end
			endcase
		end
	end

endmodule

// File: tb_core.sv
module tb_core;
	timeunit 1ns;
	timeprecision 1ps;
	import core_pkg::*;

	localparam int CLK_PERIOD = 100;
	// each bus phase of tb_imem takes one to four cycles.
	localparam int MEM_MAX_DELAY = 4;
	// program words over all tests.
	localparam int TOTAL_WORDS = 76;
	localparam int WATCHDOG_NS = TOTAL_WORDS * 40 * MEM_MAX_DELAY * CLK_PERIOD;
	localparam int RUN_LIMIT = 4000;

	logic        clk = 1'b0;
	logic        reset = 1'b1;
	logic        arvalid;
	logic        arready;
	logic [31:0] araddr;
	logic        rvalid;
	logic        rready;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        trace_valid;
	trace_s      trace;
	logic        halted;
	logic        fault;

	integer      seed = 32'h549b;
	int          errors = 0;
	int          checks = 0;
	int          tests_run = 0;

	logic [31:0] prog_img [256];
	int          prog_len;
	logic [31:0] gr [32];
	logic [31:0] fr [32];
	trace_s      exp_q [$];
	trace_s      act_q [$];
	logic [31:0] exp_addr [$];
	bit          exp_fault;

	core_top dut (
		.clk           (clk),
		.reset         (reset),
		.m_arvalid_o   (arvalid),
		.m_arready_i   (arready),
		.m_araddr_o    (araddr),
		.m_rvalid_i    (rvalid),
		.m_rready_o    (rready),
		.m_rdata_i     (rdata),
		.m_rresp_i     (rresp),
		.trace_valid_o (trace_valid),
		.trace_o       (trace),
		.halted_o      (halted),
		.fault_o       (fault)
	);

	tb_imem #(.MAX_DELAY (MEM_MAX_DELAY - 1)) imem (
		.clk_i     (clk),
		.reset_i   (reset),
		.arvalid_i (arvalid),
		.arready_o (arready),
		.araddr_i  (araddr),
		.rvalid_o  (rvalid),
		.rready_i  (rready),
		.rdata_o   (rdata),
		.rresp_o   (rresp)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the core stopped making progress", WATCHDOG_NS);
		$display("Result: FAILED");
		$finish;
	end

	function automatic logic [31:0] r_word(opcode_e op, int rs, int rt, int rd, int sh);
		r_word = {op, rs[4:0], rt[4:0], rd[4:0], sh[4:0], 6'd0};
	endfunction

	function automatic logic [31:0] i_word(opcode_e op, int rs, int rt, logic [15:0] imm);
		i_word = {op, rs[4:0], rt[4:0], imm};
	endfunction

	function automatic logic [31:0] j_word(opcode_e op, logic [25:0] target);
		j_word = {op, target};
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checks++;
		assert (actual === expected) else begin
			$display("ERROR %0d ns: %s is %h, expected %h", $time, name, actual, expected);
			errors++;
		end
	endtask

	// unused words decode as HALT with the byte address in the low bits.
	task automatic clear_image();
		for (int i = 0; i < 256; i++)
			prog_img[i] = {HALT, 26'(i * 4)};
		prog_len = 0;
	endtask

	task automatic append_word(input logic [31:0] word);
		prog_img[prog_len] = word;
		prog_len++;
	endtask

	// ISA model that runs the image until a stop or the faulting fetch.
	task automatic model_run(input bit err_on, input logic [31:0] err_at);
		logic [31:0] pc;
		logic [31:0] ir;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] f;
		logic [31:0] sext;
		logic [31:0] val;
		logic [31:0] npc;
		logic [5:0]  op;
		logic [4:0]  dest;
		bit          wg;
		bit          wf;
		bit          stop;
		trace_s      rec;
		int          steps;
		for (int i = 0; i < 32; i++) begin
			gr[i] = 32'h0;
			fr[i] = 32'h0;
		end
		exp_q.delete();
		exp_addr.delete();
		exp_fault = 1'b0;
		pc = 32'h0;
		stop = 1'b0;
		steps = 0;
		while (!stop && steps < 500) begin
			steps++;
			exp_addr.push_back(pc);
			if (err_on && pc == err_at) begin
				exp_fault = 1'b1;
				stop = 1'b1;
			end else begin
				ir = prog_img[pc[9:2]];
				op = ir[31:26];
				a = gr[ir[25:21]];
				b = gr[ir[20:16]];
				f = fr[ir[25:21]];
				sext = {{16{ir[15]}}, ir[15:0]};
				dest = ir[15:11];
				val = 32'h0;
				wg = 1'b0;
				wf = 1'b0;
				npc = pc + 32'd4;
				// which file each opcode writes, and through which field.
				case (op)
					ADD, SUB, AND, OR, XOR, SLT, SLL, SRL, SRA, MFF:
						wg = 1'b1;
					ADDI, ORI, LUI: begin
						wg = 1'b1;
						dest = ir[20:16];
					end
					MTF, FMOV, FNEG, FABS:
						wf = 1'b1;
				endcase
				case (op)
					ADD: val = a + b;
					SUB: val = a - b;
					AND: val = a & b;
					OR: val = a | b;
					XOR: val = a ^ b;
					SLT: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					SLL: val = b << ir[10:6];
					SRL: val = b >> ir[10:6];
					SRA: val = $signed(b) >>> ir[10:6];
					ADDI: val = a + sext;
					ORI: val = a | {16'h0, ir[15:0]};
					LUI: val = {ir[15:0], 16'h0};
					BEQ: begin
						if (a == b)
							npc = pc + 32'd4 + (sext << 2);
					end
					BNE: begin
						if (a != b)
							npc = pc + 32'd4 + (sext << 2);
					end
					J: npc = {npc[31:28], ir[25:0], 2'b00};
					MTF: val = a;
					MFF, FMOV: val = f;
					FNEG: val = f ^ 32'h8000_0000;
					FABS: val = f & 32'h7fff_ffff;
					// HALT, ILLEGAL and unknown codes all stop.
					default: stop = 1'b1;
				endcase
				rec.pc = pc;
				rec.instruction = ir;
				rec.dest = dest;
				rec.wrote_general = wg;
				rec.wrote_float = wf;
				rec.value = val;
				exp_q.push_back(rec);
				if (wg && dest != 5'd0)
					gr[dest] = val;
				if (wf)
					fr[dest] = val;
				pc = npc;
			end
		end
	endtask

	task automatic pulse_reset();
		@(negedge clk);
		reset = 1'b1;
		repeat (4) @(negedge clk);
		check_value("m_arvalid_o", 32'(arvalid), 32'd0);
		check_value("m_rready_o", 32'(rready), 32'd0);
		check_value("trace_valid_o", 32'(trace_valid), 32'd0);
		check_value("halted_o", 32'(halted), 32'd0);
		check_value("fault_o", 32'(fault), 32'd0);
		reset = 1'b0;
	endtask

	task automatic run_dut();
		int cycles;
		act_q.delete();
		cycles = 0;
		while (!halted && cycles < RUN_LIMIT) begin
			@(negedge clk);
			if (trace_valid)
				act_q.push_back(trace);
			cycles++;
		end
		assert (halted) else begin
			$display("core did not reach halted_o within %0d cycles", RUN_LIMIT);
			errors++;
		end
		// nothing may retire or fetch once halted.
		repeat (8) begin
			@(negedge clk);
			if (trace_valid)
				act_q.push_back(trace);
		end
	endtask

	task automatic compare_run();
		trace_s a;
		trace_s e;
		int     n;
		check_value("trace record count", act_q.size(), exp_q.size());
		n = (act_q.size() < exp_q.size()) ? act_q.size() : exp_q.size();
		for (int i = 0; i < n; i++) begin
			a = act_q[i];
			e = exp_q[i];
			check_value($sformatf("trace_o.pc #%0d", i), a.pc, e.pc);
			check_value($sformatf("trace_o.instruction #%0d", i), a.instruction, e.instruction);
			check_value($sformatf("trace_o.wrote_general #%0d", i),
				32'(a.wrote_general), 32'(e.wrote_general));
			check_value($sformatf("trace_o.wrote_float #%0d", i),
				32'(a.wrote_float), 32'(e.wrote_float));
			if (e.wrote_general || e.wrote_float) begin
				check_value($sformatf("trace_o.dest #%0d", i), 32'(a.dest), 32'(e.dest));
				check_value($sformatf("trace_o.value #%0d", i), a.value, e.value);
			end
		end
		check_value("fetch count", imem.n_fetch, exp_addr.size());
		n = (imem.n_fetch < exp_addr.size()) ? imem.n_fetch : exp_addr.size();
		if (n > 64)
			n = 64;
		for (int i = 0; i < n; i++)
			check_value($sformatf("m_araddr_o #%0d", i), imem.addr_log[i], exp_addr[i]);
		checks++;
		assert (imem.rready_errors == 0) else begin
			$display("m_rready_o was out of step with the address handshake on %0d cycles",
				imem.rready_errors);
			errors++;
		end
		check_value("halted_o", 32'(halted), 32'd1);
		check_value("fault_o", 32'(fault), 32'(exp_fault));
	endtask

	task automatic execute(input string name, input bit err_on, input logic [31:0] err_at);
		int errors_before;
		errors_before = errors;
		for (int i = 0; i < 256; i++)
			imem.mem[i] = prog_img[i];
		imem.err_en = err_on;
		imem.err_addr = err_at;
		model_run(err_on, err_at);
		pulse_reset();
		run_dut();
		compare_run();
		tests_run++;
		$display("%s: %0d records, %0d errors", name, act_q.size(), errors - errors_before);
	endtask

	task automatic alu_register_ops();
		logic [31:0] x;
		logic [31:0] y;
		x = $random(seed);
		y = $random(seed);
		clear_image();
		append_word(i_word(LUI, 0, 1, x[31:16]));
		append_word(i_word(ADDI, 1, 1, x[15:0]));
		append_word(i_word(LUI, 0, 2, y[31:16]));
		append_word(i_word(ADDI, 2, 2, y[15:0]));
		append_word(r_word(ADD, 1, 2, 3, 0));
		append_word(r_word(SUB, 1, 2, 4, 0));
		append_word(r_word(AND, 1, 2, 5, 0));
		append_word(r_word(OR, 1, 2, 6, 0));
		append_word(r_word(XOR, 1, 2, 7, 0));
		append_word(r_word(SLT, 1, 2, 8, 0));
		append_word(r_word(SLT, 2, 1, 9, 0));
		append_word(j_word(HALT, 26'd0));
		execute("alu_register_ops", 1'b0, 32'h0);
	endtask

	task automatic immediate_extension();
		clear_image();
		append_word(i_word(ADDI, 0, 1, 16'h8000));
		append_word(i_word(ADDI, 0, 2, 16'h7fff));
		append_word(i_word(ORI, 0, 3, 16'h8001));
		append_word(i_word(ORI, 1, 4, 16'h00ff));
		append_word(i_word(LUI, 0, 5, 16'hdead));
		// writes to r0 must not stick.
		append_word(i_word(ADDI, 0, 0, 16'h1234));
		append_word(i_word(ORI, 0, 0, 16'hffff));
		append_word(r_word(ADD, 0, 0, 6, 0));
		append_word(r_word(ADD, 0, 2, 7, 0));
		append_word(j_word(HALT, 26'd0));
		execute("immediate_extension", 1'b0, 32'h0);
	endtask

	task automatic serial_shifts();
		logic [31:0] x;
		logic [31:0] y;
		opcode_e     op;
		int          amt;
		x = $random(seed);
		y = $random(seed) | 32'h8000_0000;
		clear_image();
		append_word(i_word(LUI, 0, 1, x[31:16]));
		append_word(i_word(ORI, 1, 1, x[15:0]));
		append_word(i_word(LUI, 0, 4, y[31:16]));
		append_word(i_word(ORI, 4, 4, y[15:0]));
		for (int k = 0; k < 12; k++) begin
			case (k % 3)
				0: op = SLL;
				1: op = SRL;
				default: op = SRA;
			endcase
			if (k < 3)
				amt = 0;
			else if (k < 6)
				amt = 31;
			else
				amt = $random(seed) & 31;
			append_word(r_word(op, 0, (k % 2 == 1) ? 4 : 1, 5 + k, amt));
		end
		append_word(j_word(HALT, 26'd0));
		execute("serial_shifts", 1'b0, 32'h0);
	endtask

	task automatic branches_and_jump();
		clear_image();
		append_word(i_word(ADDI, 0, 1, 16'd5));
		append_word(i_word(ADDI, 0, 2, 16'd5));
		append_word(i_word(ADDI, 0, 3, 16'd7));
		append_word(i_word(BEQ, 1, 2, 16'd2));
		append_word(i_word(ADDI, 0, 4, 16'd1));
		append_word(i_word(ADDI, 0, 4, 16'd2));
		append_word(i_word(BEQ, 1, 3, 16'd1));
		append_word(i_word(BNE, 1, 3, 16'd1));
		append_word(i_word(ADDI, 0, 5, 16'd3));
		append_word(i_word(BNE, 1, 2, 16'd5));
		append_word(j_word(J, 26'd13));
		append_word(i_word(ADDI, 0, 6, 16'd9));
		append_word(j_word(HALT, 26'd0));
		// backward branch to the word at byte 44.
		append_word(i_word(BEQ, 0, 0, 16'hfffd));
		execute("branches_and_jump", 1'b0, 32'h0);
	endtask

	task automatic float_moves();
		clear_image();
		append_word(i_word(LUI, 0, 1, 16'hc0a0));
		append_word(i_word(ORI, 1, 1, 16'h5555));
		append_word(r_word(MTF, 1, 0, 3, 0));
		append_word(r_word(FMOV, 3, 0, 4, 0));
		append_word(r_word(FNEG, 3, 0, 5, 0));
		append_word(r_word(FNEG, 5, 0, 6, 0));
		append_word(r_word(FABS, 3, 0, 7, 0));
		append_word(r_word(FABS, 5, 0, 8, 0));
		append_word(r_word(MTF, 1, 0, 0, 0));
		append_word(r_word(MFF, 0, 0, 9, 0));
		append_word(r_word(MFF, 4, 0, 2, 0));
		append_word(r_word(MFF, 6, 0, 3, 0));
		append_word(r_word(MFF, 8, 0, 4, 0));
		append_word(j_word(HALT, 26'd0));
		execute("float_moves", 1'b0, 32'h0);
	endtask

	task automatic halt_and_fault();
		clear_image();
		append_word(i_word(ADDI, 0, 1, 16'd1));
		append_word(j_word(HALT, 26'd0));
		append_word(i_word(ADDI, 0, 2, 16'd2));
		execute("halt_stop", 1'b0, 32'h0);

		clear_image();
		append_word(i_word(ADDI, 0, 1, 16'd7));
		append_word({6'h2a, 26'd0});
		append_word(i_word(ADDI, 0, 2, 16'd2));
		execute("illegal_stop", 1'b0, 32'h0);

		// third fetch answers SLVERR.
		clear_image();
		append_word(i_word(ADDI, 0, 1, 16'd1));
		append_word(i_word(ADDI, 0, 2, 16'd2));
		append_word(i_word(ADDI, 0, 3, 16'd3));
		execute("fetch_fault", 1'b1, 32'd8);
	endtask

	initial begin
		alu_register_ops();
		immediate_extension();
		serial_shifts();
		branches_and_jump();
		float_moves();
		halt_and_fault();
		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// File: filelist.f
+incdir+.
core_pkg.sv
inst_fetcher.sv
inst_decoder.sv
executor.sv
register_files.sv
core_controller.sv
core_top.sv
tb_imem.sv
tb_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_core
RTL_TOP ?= core_top
FILELIST ?= filelist.f
MDIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
PASS_MSG ?= Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(MDIR)

run: build
	@out="$$(./$(MDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(MDIR)
